/* music_consts.svh */
`ifndef MUSIC_CONSTS_SVH
`define MUSIC_CONSTS_SVH

// field widths
`define FREQ_W 10
`define BEAT_W 10
`define TPM_W 16
`define PART_W 3
`define NOTE_W 6

// apb register map
`define ADDR_CTRL 8'h00
`define ADDR_TPM 8'h04
`define ADDR_BEAT 8'h08
`define ADDR_STATUS 8'h0c

// notes per song section
`define INTRO_LEN 13
`define VERSE_LEN 16
`define CHORUS_LEN 16

`define BEAT_RESET 100 // ms per beat
`define TPM_RESET 1000 // clocks per ms

`endif

/* music_pkg.sv */
`include "music_consts.svh"

package music_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic              play;
    logic [`TPM_W-1:0]  ticks_per_milli;
    logic [`BEAT_W-1:0] beat_len;
  } player_cfg_t;

  typedef struct packed {
    logic [`FREQ_W-1:0] freq; // 0 means rest
    logic [`BEAT_W-1:0] beats;
  } note_t;

  typedef enum logic [1:0] {
    SEC_INTRO,
    SEC_VERSE,
    SEC_CHORUS
  } section_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_NOTE,
    ST_GAP
  } seq_state_e;

  typedef struct packed {
    logic [`PART_W-1:0] part; // 1..6 while playing, 0 when idle
    logic [`NOTE_W-1:0] note_idx;
    logic               sounding;
  } seq_status_t;

endpackage

/* apb_regs.sv */
`include "music_consts.svh"

module apb_regs (
  input  logic                   clk,
  input  logic                   rst,
  input  music_pkg::apb_req_t    req,
  output music_pkg::apb_rsp_t    rsp,
  output music_pkg::player_cfg_t cfg,
  input  music_pkg::seq_status_t status
);

  logic        access;
  logic        addr_ok;
  logic [31:0] status_word;

  assign access  = req.psel && req.penable; // second cycle of a transfer
  assign addr_ok = req.paddr inside {`ADDR_CTRL, `ADDR_TPM, `ADDR_BEAT, `ADDR_STATUS};

  // part in 2:0, note index in 13:8, sounding in 16
  assign status_word = {15'b0, status.sounding, 2'b0, status.note_idx, 5'b0, status.part};

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.play            <= 1'b0;
      cfg.ticks_per_milli <= `TPM_W'(`TPM_RESET);
      cfg.beat_len        <= `BEAT_W'(`BEAT_RESET);
    end else if (access && req.pwrite) begin
      case (req.paddr)
        `ADDR_CTRL: cfg.play <= req.pwdata[0];
        `ADDR_TPM:  cfg.ticks_per_milli <= req.pwdata[`TPM_W-1:0];
        `ADDR_BEAT: cfg.beat_len <= req.pwdata[`BEAT_W-1:0];
        default: ; // status is read only
      endcase
    end
  end

  always_comb begin
    case (req.paddr)
      `ADDR_CTRL:   rsp.prdata = {31'b0, cfg.play};
      `ADDR_TPM:    rsp.prdata = 32'(cfg.ticks_per_milli);
      `ADDR_BEAT:   rsp.prdata = 32'(cfg.beat_len);
      `ADDR_STATUS: rsp.prdata = status_word;
      default:      rsp.prdata = 32'b0;
    endcase
    rsp.pready  = 1'b1; // no wait states
    rsp.pslverr = access && !addr_ok;
  end

endmodule

/* song_rom.sv */
`include "music_consts.svh"

module song_rom (
  input  music_pkg::section_e section,
  input  logic [`NOTE_W-1:0]  note_idx,
  output music_pkg::note_t    note
);
  import music_pkg::*;

  // entries are {freq in Hz, beats}
  always_comb begin
    note = '0;
    case (section)
      SEC_INTRO: begin
        case (note_idx)
          6'd0:  note = '{10'd554, 10'd6};  // c5s
          6'd1:  note = '{10'd622, 10'd10}; // e5f
          6'd2:  note = '{10'd622, 10'd6};
          6'd3:  note = '{10'd698, 10'd6};  // f5
          6'd4:  note = '{10'd831, 10'd1};  // a5f
          6'd5:  note = '{10'd740, 10'd1};  // f5s
          6'd6:  note = '{10'd698, 10'd1};
          6'd7:  note = '{10'd622, 10'd1};
          6'd8:  note = '{10'd554, 10'd6};
          6'd9:  note = '{10'd622, 10'd10};
          6'd10: note = '{10'd0,   10'd4};  // rest
          6'd11: note = '{10'd415, 10'd2};  // a4f
          6'd12: note = '{10'd415, 10'd10};
          default: note = '0;
        endcase
      end
      SEC_VERSE: begin
        case (note_idx)
          6'd0:  note = '{10'd0,   10'd6}; // rest
          6'd1:  note = '{10'd277, 10'd1}; // c4s
          6'd2:  note = '{10'd277, 10'd1};
          6'd3:  note = '{10'd277, 10'd1};
          6'd4:  note = '{10'd277, 10'd1};
          6'd5:  note = '{10'd311, 10'd2}; // e4f
          6'd6:  note = '{10'd0,   10'd1};
          6'd7:  note = '{10'd261, 10'd1}; // c4
          6'd8:  note = '{10'd233, 10'd1}; // b3f
          6'd9:  note = '{10'd208, 10'd5}; // a3f
          6'd10: note = '{10'd0,   10'd1};
          6'd11: note = '{10'd233, 10'd1};
          6'd12: note = '{10'd233, 10'd1};
          6'd13: note = '{10'd261, 10'd1};
          6'd14: note = '{10'd277, 10'd3};
          6'd15: note = '{10'd208, 10'd1};
          default: note = '0;
        endcase
      end
      SEC_CHORUS: begin
        case (note_idx)
          6'd0:  note = '{10'd466, 10'd1}; // b4f
          6'd1:  note = '{10'd466, 10'd1};
          6'd2:  note = '{10'd415, 10'd1}; // a4f
          6'd3:  note = '{10'd415, 10'd1};
          6'd4:  note = '{10'd698, 10'd3}; // f5
          6'd5:  note = '{10'd698, 10'd3};
          6'd6:  note = '{10'd622, 10'd6}; // e5f
          6'd7:  note = '{10'd466, 10'd1};
          6'd8:  note = '{10'd466, 10'd1};
          6'd9:  note = '{10'd415, 10'd1};
          6'd10: note = '{10'd415, 10'd1};
          6'd11: note = '{10'd622, 10'd3};
          6'd12: note = '{10'd622, 10'd3};
          6'd13: note = '{10'd554, 10'd3}; // c5s
          6'd14: note = '{10'd523, 10'd1}; // c5
          6'd15: note = '{10'd466, 10'd2};
          default: note = '0;
        endcase
      end
      default: note = '0;
    endcase
  end

endmodule

/* note_sequencer.sv */
`include "music_consts.svh"

module note_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  music_pkg::player_cfg_t cfg,
  output music_pkg::section_e    section,
  output logic [`NOTE_W-1:0]     note_idx,
  input  music_pkg::note_t       note,
  output logic [`FREQ_W-1:0]     tone_freq,
  output music_pkg::seq_status_t status
);
  import music_pkg::*;

  localparam int DUR_W = 2 * `BEAT_W + 1; // beat_len * beats * 2

  seq_state_e           state;
  logic [`PART_W-1:0]   part;
  logic [`TPM_W-1:0]    tick_cnt;
  logic                 ms_tick;
  logic [DUR_W-1:0]     ms_cnt;
  logic [DUR_W-1:0]     limit;    // length of current note or gap in ms
  logic [DUR_W-1:0]     gap_len;
  logic [2*`BEAT_W-1:0] base_len;
  logic [DUR_W-1:0]     dur;
  logic                 ms_done;
  logic                 advance;
  logic                 last_note;

  // parts 1,2 intro; 3,5 verse; 4,6 chorus
  always_comb begin
    case (part)
      3'd3, 3'd5: section = SEC_VERSE;
      3'd4, 3'd6: section = SEC_CHORUS;
      default:    section = SEC_INTRO;
    endcase
  end

  always_comb begin
    case (section)
      SEC_VERSE:  last_note = note_idx == `NOTE_W'(`VERSE_LEN - 1);
      SEC_CHORUS: last_note = note_idx == `NOTE_W'(`CHORUS_LEN - 1);
      default:    last_note = note_idx == `NOTE_W'(`INTRO_LEN - 1);
    endcase
  end

  assign base_len = cfg.beat_len * note.beats;
  assign dur      = (section == SEC_VERSE) ? {base_len, 1'b0} : {1'b0, base_len};
  assign gap_len  = limit / DUR_W'(3);

  assign ms_tick = cfg.play && (tick_cnt == cfg.ticks_per_milli);
  assign ms_done = ms_tick && ((ms_cnt + 1'b1) >= limit);

  // move on to the next note: after a gap, after a rest, or when the gap is empty
  always_comb begin
    advance = 1'b0;
    if (ms_done) begin
      if (state == ST_GAP) advance = 1'b1;
      else if (state == ST_NOTE && (tone_freq == '0 || gap_len == '0)) advance = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt <= '0;
    end else if (!cfg.play || ms_tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !cfg.play) begin // stop clears the player
      state     <= ST_IDLE;
      part      <= '0;
      note_idx  <= '0;
      tone_freq <= '0;
      ms_cnt    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          state    <= ST_FETCH;
          part     <= `PART_W'(1);
          note_idx <= '0;
        end
        ST_FETCH: begin
          limit     <= dur;
          tone_freq <= note.freq;
          ms_cnt    <= '0;
          state     <= ST_NOTE;
        end
        ST_NOTE: begin
          if (ms_done) begin
            tone_freq <= '0;
            ms_cnt    <= '0;
            limit     <= gap_len;
            state     <= advance ? ST_FETCH : ST_GAP;
          end else if (ms_tick) begin
            ms_cnt <= ms_cnt + 1'b1;
          end
        end
        ST_GAP: begin
          if (ms_done) state <= ST_FETCH;
          else if (ms_tick) ms_cnt <= ms_cnt + 1'b1;
        end
        default: state <= ST_IDLE;
      endcase

      if (advance) begin
        if (last_note) begin
          note_idx <= '0;
          part     <= (part == `PART_W'(6)) ? `PART_W'(1) : part + 1'b1; // wrap after part 6
        end else begin
          note_idx <= note_idx + 1'b1;
        end
      end
    end
  end

  assign status.part     = part;
  assign status.note_idx = note_idx;
  assign status.sounding = (state == ST_NOTE) && (tone_freq != '0);

endmodule

/* tone_gen.sv */
`include "music_consts.svh"

module tone_gen (
  input  logic               clk,
  input  logic               rst,
  input  logic [`TPM_W-1:0]  ticks_per_milli,
  input  logic [`FREQ_W-1:0] freq,
  output logic               sound
);

  logic [31:0] acc;
  logic [31:0] half_period;
  logic [31:0] acc_next;

  assign half_period = 32'd500 * 32'(ticks_per_milli); // half of clocks per second
  assign acc_next    = acc + 32'(freq);

  always_ff @(posedge clk) begin
    if (rst) begin
      acc   <= '0;
      sound <= 1'b0;
    end else if (freq == '0) begin
      sound <= 1'b0; // silent, phase held
    end else if (acc >= half_period) begin
      acc   <= acc_next - half_period;
      sound <= !sound;
    end else begin
      acc <= acc_next;
    end
  end

endmodule

/* seg_display.sv */
module seg_display (
  input  music_pkg::seq_status_t status,
  output logic [7:0]             led
);

  logic [3:0] digit;

  assign digit = 4'(status.part);

  // segment bits 6..0 are g f e d c b a
  always_comb begin
    case (digit)
      4'd0:    led[6:0] = 7'b0000000; // blank when idle
      4'd1:    led[6:0] = 7'b0000110;
      4'd2:    led[6:0] = 7'b1011011;
      4'd3:    led[6:0] = 7'b1001111;
      4'd4:    led[6:0] = 7'b1100110;
      4'd5:    led[6:0] = 7'b1101101;
      4'd6:    led[6:0] = 7'b1111100;
      4'd7:    led[6:0] = 7'b0000111;
      4'd8:    led[6:0] = 7'b1111111;
      4'd9:    led[6:0] = 7'b1100111;
      default: led[6:0] = 7'b0000000;
    endcase
  end

  assign led[7] = status.sounding; // dot while a note plays

endmodule

/* music_player.sv */
`include "music_consts.svh"

module music_player (
  input  logic                clk,
  input  logic                rst,
  input  music_pkg::apb_req_t apb_req,
  output music_pkg::apb_rsp_t apb_rsp,
  output logic                sound,
  output logic [7:0]          led
);
  import music_pkg::*;

  player_cfg_t        cfg;
  seq_status_t        status;
  section_e           section;
  logic [`NOTE_W-1:0] note_idx;
  note_t              note;
  logic [`FREQ_W-1:0] tone_freq;

  apb_regs u_apb_regs (
    .clk    (clk),
    .rst    (rst),
    .req    (apb_req),
    .rsp    (apb_rsp),
    .cfg    (cfg),
    .status (status)
  );

  note_sequencer u_note_sequencer (
    .clk       (clk),
    .rst       (rst),
    .cfg       (cfg),
    .section   (section),
    .note_idx  (note_idx),
    .note      (note),
    .tone_freq (tone_freq),
    .status    (status)
  );

  song_rom u_song_rom (
    .section  (section),
    .note_idx (note_idx),
    .note     (note)
  );

  tone_gen u_tone_gen (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (cfg.ticks_per_milli),
    .freq            (tone_freq),
    .sound           (sound)
  );

  seg_display u_seg_display (
    .status (status),
    .led    (led)
  );

endmodule

/* tb_music_player.sv */
`include "music_consts.svh"

module tb_music_player;
  timeunit 1ns;
  timeprecision 1ps;
  import music_pkg::*;

  logic       clk;
  logic       rst;
  apb_req_t   req;
  apb_rsp_t   rsp;
  logic       sound;
  logic [7:0] led;

  logic [6:0] seg_queue[$]; // expected part codes in display order
  int         tpm_set;      // last values written over apb
  int         beat_set;
  int         song_cycles = 0;

  // melody and rhythm in song order, rests have frequency 0
  int intro_f[13]  = '{554, 622, 622, 698, 831, 740, 698, 622, 554, 622, 0, 415, 415};
  int intro_b[13]  = '{6, 10, 6, 6, 1, 1, 1, 1, 6, 10, 4, 2, 10};
  int verse_f[16]  = '{0, 277, 277, 277, 277, 311, 0, 261, 233, 208, 0, 233, 233, 261, 277, 208};
  int verse_b[16]  = '{6, 1, 1, 1, 1, 2, 1, 1, 1, 5, 1, 1, 1, 1, 3, 1};
  int chorus_f[16] = '{466, 466, 415, 415, 698, 698, 622, 466, 466, 415, 415, 622, 622, 554, 523, 466};
  int chorus_b[16] = '{1, 1, 1, 1, 3, 3, 6, 1, 1, 1, 1, 3, 3, 3, 1, 2};

  music_player UUT (
    .clk     (clk),
    .rst     (rst),
    .apb_req (req),
    .apb_rsp (rsp),
    .sound   (sound),
    .led     (led)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic data_line_error(input logic [7:0] cmd);
    $display("Errors found");
    $fatal(1, "malformed %c line in music_testdata.txt", cmd);
  endtask

  // 0 intro, 1 verse, 2 chorus
  function automatic int section_of(int p);
    if (p == 3 || p == 5) return 1;
    if (p == 4 || p == 6) return 2;
    return 0;
  endfunction

  function automatic int part_length(int p);
    case (section_of(p))
      0: return `INTRO_LEN;
      1: return `VERSE_LEN;
      default: return `CHORUS_LEN;
    endcase
  endfunction

  function automatic int table_freq(int p, int i);
    case (section_of(p))
      0: return intro_f[i];
      1: return verse_f[i];
      default: return chorus_f[i];
    endcase
  endfunction

  function automatic int table_beats(int p, int i);
    case (section_of(p))
      0: return intro_b[i];
      1: return verse_b[i];
      default: return chorus_b[i];
    endcase
  endfunction

  task automatic next_note(inout int p, inout int i);
    i = i + 1;
    if (i == part_length(p)) begin
      i = 0;
      p = (p == 6) ? 1 : p + 1; // song wraps to the first intro
    end
  endtask

  // upper bound of one pass through the song in clock cycles
  function automatic int song_length(int tpm, int beat);
    int cycles;
    int dur;
    int p;
    int i;
    cycles = 0;
    for (p = 1; p <= 6; p++) begin
      for (i = 0; i < part_length(p); i++) begin
        dur = beat * table_beats(p, i);
        if (section_of(p) == 1) dur = dur * 2; // verse runs at half speed
        if (table_freq(p, i) != 0) dur = dur + dur / 3;
        cycles = cycles + dur * (tpm + 1) + 1; // plus the fetch cycle
      end
    end
    return cycles;
  endfunction

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    req.penable <= 1'b1;
    @(posedge clk);
    req <= '0;
    if (addr == `ADDR_TPM) tpm_set = int'(data[`TPM_W-1:0]);
    if (addr == `ADDR_BEAT) beat_set = int'(data[`BEAT_W-1:0]);
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
                          input logic exp_err);
    @(posedge clk);
    req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'b0};
    @(posedge clk);
    req.penable <= 1'b1;
    @(negedge clk); // access cycle
    check(rsp.prdata, exp_data, $sformatf("read data at address %0h", addr));
    check(32'(rsp.pslverr), 32'(exp_err), $sformatf("pslverr at address %0h", addr));
    check(32'(rsp.pready), 32'd1, $sformatf("pready at address %0h", addr));
    @(posedge clk);
    req <= '0;
  endtask

  // follows the display and the tone until the expected part list is used up
  task automatic follow_song();
    logic [6:0] shown;
    logic       dot_prev;
    logic       snd;
    int         acc;
    int         half;
    int         freq_now;
    int         p;
    int         i;
    shown    = 7'd0;
    dot_prev = 1'b0;
    snd      = 1'b0;
    acc      = 0;
    freq_now = 0;
    p        = 1;
    i        = 0;
    half     = 500 * tpm_set;
    song_cycles = 2 * song_length(tpm_set, beat_set) + 100;
    while (seg_queue.size() != 0) begin
      @(negedge clk);
      if (!led[7] && !dot_prev) check(32'(sound), 32'd0, "sound during a gap or rest");
      check(32'(sound), 32'(snd), "tone output against the accumulator model");
      if (led[7] && !dot_prev) begin // new note fetched, rests show no dot
        while (table_freq(p, i) == 0) next_note(p, i);
        freq_now = table_freq(p, i);
        next_note(p, i);
      end
      if (led[6:0] != shown) begin
        shown = led[6:0];
        check(32'(shown), 32'(seg_queue.pop_front()), "segment code of the part");
      end
      if (!led[7]) begin
        snd = 1'b0; // silent, phase held
      end else if (acc >= half) begin
        acc = acc + freq_now - half;
        snd = !snd;
      end else begin
        acc = acc + freq_now;
      end
      dot_prev = led[7];
    end
  endtask

  task automatic check_stopped();
    repeat (2) @(posedge clk);
    @(negedge clk);
    check(32'(led), 32'd0, "led after play was cleared");
    check(32'(sound), 32'd0, "sound after play was cleared");
  endtask

  initial begin
    wait (song_cycles != 0);
    repeat (song_cycles) @(posedge clk);
    $display("Errors found");
    $fatal(1, "timeout, the song did not finish within %0d cycles", song_cycles);
  end

  initial begin
    int          fd;
    int          r;
    int          ch;
    logic [7:0]  cmd;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] err;
    req      = '0;
    rst      = 1'b1;
    tpm_set  = `TPM_RESET;
    beat_set = `BEAT_RESET;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check(32'(sound), 32'd0, "sound after reset");
    check(32'(led), 32'd0, "led after reset");
    fd = $fopen("music_testdata.txt", "r");
    if (fd == 0) begin
      $display("Errors found");
      $fatal(1, "cannot open music_testdata.txt");
    end
    while ($fscanf(fd, " %c", cmd) == 1) begin
      case (cmd)
        "#": begin
          do begin
            ch = $fgetc(fd);
          end while (ch != 10 && ch != -1);
        end
        "W": begin
          r = $fscanf(fd, "%h %h", addr, data);
          if (r != 2) data_line_error(cmd);
          apb_write(addr[7:0], data);
        end
        "R": begin
          r = $fscanf(fd, "%h %h %h", addr, data, err);
          if (r != 3) data_line_error(cmd);
          apb_read(addr[7:0], data, err[0]);
        end
        "S": begin
          r = $fscanf(fd, "%h", data);
          if (r != 1) data_line_error(cmd);
          seg_queue.push_back(data[6:0]);
        end
        "M": follow_song();
        "Z": check_stopped();
        default: begin
          $display("Errors found");
          $fatal(1, "unknown command %c in music_testdata.txt", cmd);
        end
      endcase
    end
    $fclose(fd);
    $display("No errors");
    $finish;
  end

endmodule

/* music_testdata.txt */
# W addr data | R addr expected_data expected_pslverr | S expected led code, all hex
# M plays and follows the led code list, Z checks that stopping clears the outputs
R 00 00000000 0
R 04 000003e8 0
R 08 00000064 0
R 0c 00000000 0
W 04 00001234
W 08 00000155
R 04 00001234 0
R 08 00000155 0
W 10 00000077
R 10 00000000 1
R 04 00001234 0
R 08 00000155 0
W 04 00000004
W 08 00000001
R 04 00000004 0
R 08 00000001 0
S 06
S 5b
S 4f
S 66
S 6d
S 7c
S 06
W 00 00000001
M
W 00 00000000
Z
R 00 00000000 0

/* filelist.f */
+incdir+.
music_pkg.sv
apb_regs.sv
song_rom.sv
note_sequencer.sv
tone_gen.sv
seg_display.sv
music_player.sv
tb_music_player.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_music_player
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
